/* rtl/pfir_pkg.sv */
package pfir_pkg;

	// sample and coefficient widths
	localparam int DIN_W = 18;
	localparam int COEF_W = 28;
	localparam int DOUT_W = 20;
	localparam int PROG_W = 16;

	// filter depth
	localparam int NTAPS = 64;
	localparam int TAP_AW = 6;
	localparam int DEC_W = 6;

	// 46-bit product plus guard bits for 64 taps
	localparam int ACC_W = 52;

	// accumulator bit that lands on output bit 0
	localparam int OUT_SHIFT = 25;

	typedef logic signed [DIN_W-1:0] sample_t;
	typedef logic signed [COEF_W-1:0] coef_t;
	typedef logic signed [DOUT_W-1:0] dout_t;
	typedef logic signed [ACC_W-1:0] acc_t;
	typedef logic [TAP_AW-1:0] tap_t;
	typedef logic [PROG_W-1:0] prog_t;
	typedef logic [DEC_W-1:0] dec_t;

	// control sequencer states
	typedef enum logic [1:0]
	{
		ST_IDLE,
		ST_RUN,
		ST_DRAIN,
		ST_HOLD
	} fir_state_t;

endpackage

/* rtl/coef_store.sv */
module coef_store (
	input  logic            clk,
	input  logic            rst_n,
	input  pfir_pkg::prog_t pdata,
	input  logic            pwr,
	input  logic            prst,
	input  pfir_pkg::tap_t  rd_tap,
	output pfir_pkg::coef_t rd_coef
);
	import pfir_pkg::*;

	coef_t mem [NTAPS];

	// write side state
	tap_t  wr_addr;
	logic  hi_word;
	prog_t lo_word;

	logic  take_lo;
	logic  take_hi;

	// first word of a pair is the low half, second completes the entry
	assign take_lo = pwr && !prst && !hi_word;
	assign take_hi = pwr && !prst && hi_word;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_addr <= '0;
			hi_word <= 1'b0;
		end
		else if (prst)
		begin
			wr_addr <= '0;
			hi_word <= 1'b0;
		end
		else if (pwr)
		begin
			hi_word <= !hi_word;
			// advance only once the entry is complete
			if (hi_word)
				wr_addr <= wr_addr + 1'b1;
		end
	end

	// low half waits here for its partner word
	always_ff @(posedge clk)
	begin
		if (take_lo)
			lo_word <= pdata;
	end

	// upper nibble of the high word carries nothing here
	always_ff @(posedge clk)
	begin
		if (take_hi)
			mem[wr_addr] <= {pdata[COEF_W-PROG_W-1:0], lo_word};
	end

	// registered read, one cycle after the tap address
	always_ff @(posedge clk)
	begin
		rd_coef <= mem[rd_tap];
	end

endmodule

/* rtl/sample_buffer.sv */
module sample_buffer (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              mrst,
	input  pfir_pkg::sample_t dix,
	input  pfir_pkg::sample_t diy,
	input  logic              samp_we,
	input  pfir_pkg::tap_t    rd_tap,
	output pfir_pkg::sample_t rd_x,
	output pfir_pkg::sample_t rd_y
);
	import pfir_pkg::*;

	sample_t mem_x [NTAPS];
	sample_t mem_y [NTAPS];

	// one bit per entry, cleared by mrst without touching the memory
	logic [NTAPS-1:0] vld;

	// position of the newest sample
	tap_t newest;
	tap_t wr_addr;
	tap_t rd_addr;

	assign wr_addr = newest + 1'b1;
	// tap k looks k samples back from the newest
	assign rd_addr = newest - rd_tap;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			newest <= '0;
			vld <= '0;
		end
		else if (mrst)
			vld <= '0;
		else if (samp_we)
		begin
			newest <= wr_addr;
			vld[wr_addr] <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (samp_we && !mrst)
		begin
			mem_x[wr_addr] <= dix;
			mem_y[wr_addr] <= diy;
		end
	end

	// entries not written since the last clear read as zero
	always_ff @(posedge clk)
	begin
		rd_x <= vld[rd_addr] ? mem_x[rd_addr] : '0;
		rd_y <= vld[rd_addr] ? mem_y[rd_addr] : '0;
	end

endmodule

/* rtl/fir_control.sv */
module fir_control (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           mrst,
	input  logic           iv,
	output logic           rfd,
	input  pfir_pkg::dec_t dec,
	input  pfir_pkg::tap_t ncoef,
	output logic           samp_we,
	output pfir_pkg::tap_t rd_tap,
	output logic           mac_first,
	output logic           mac_en,
	input  logic           acc_valid,
	input  logic           out_full,
	output logic           out_load
);
	import pfir_pkg::*;

	fir_state_t state;
	fir_state_t state_nxt;

	// samples accepted since the last run
	dec_t dec_cnt;
	logic [DEC_W:0] cnt_inc;
	tap_t tap_cnt;

	logic accept;
	logic last_phase;
	logic trigger;
	logic hold_done;
	logic issue;
	logic issue_first;

	assign hold_done = (state == ST_HOLD) && !out_full;
	assign rfd = ((state == ST_IDLE) || hold_done) && !out_full && !mrst;
	assign accept = iv && rfd;
	assign samp_we = accept;

	// dec of 0 behaves like 1
	assign cnt_inc = dec_cnt + 1'b1;
	assign last_phase = cnt_inc >= {1'b0, dec};
	assign trigger = accept && last_phase;

	assign issue = (state == ST_RUN);
	assign issue_first = issue && (tap_cnt == '0);
	assign rd_tap = tap_cnt;

	// a run only starts with the output stage empty
	assign out_load = (state == ST_DRAIN) && acc_valid;

	always_comb
	begin
		state_nxt = state;
		case (state)
			ST_IDLE:
				if (trigger)
					state_nxt = ST_RUN;
			ST_RUN:
				if (tap_cnt == ncoef)
					state_nxt = ST_DRAIN;
			ST_DRAIN:
				if (acc_valid)
					state_nxt = ST_HOLD;
			ST_HOLD:
				// stage emptied so accept again right away
				if (hold_done)
					state_nxt = trigger ? ST_RUN : ST_IDLE;
			default:
				state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= ST_IDLE;
			dec_cnt <= '0;
			tap_cnt <= '0;
			mac_en <= 1'b0;
			mac_first <= 1'b0;
		end
		else if (mrst)
		begin
			state <= ST_IDLE;
			dec_cnt <= '0;
			tap_cnt <= '0;
			mac_en <= 1'b0;
			mac_first <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			if (accept)
				dec_cnt <= last_phase ? '0 : cnt_inc[DEC_W-1:0];
			if (issue)
				tap_cnt <= tap_cnt + 1'b1;
			else
				tap_cnt <= '0;
			// delayed by the memory read so they line up with the data
			mac_en <= issue;
			mac_first <= issue_first;
		end
	end

endmodule

/* rtl/mac_unit.sv */
module mac_unit (
	input  logic              clk,
	input  logic              rst_n,
	input  pfir_pkg::sample_t rd_x,
	input  pfir_pkg::sample_t rd_y,
	input  pfir_pkg::coef_t   rd_coef,
	input  logic              mac_first,
	input  logic              mac_en,
	output pfir_pkg::acc_t    acc_x,
	output pfir_pkg::acc_t    acc_y,
	output logic              acc_valid
);
	import pfir_pkg::*;

	// stage 1 products
	acc_t p_x;
	acc_t p_y;
	logic p_en;
	logic p_first;

	// stage 2 accumulator qualifier
	logic a_en;

	// both channels share one coefficient
	always_ff @(posedge clk)
	begin
		if (mac_en)
		begin
			p_x <= rd_x * rd_coef;
			p_y <= rd_y * rd_coef;
		end
	end

	// first product of a run restarts the sum
	always_ff @(posedge clk)
	begin
		if (p_en)
		begin
			acc_x <= p_first ? p_x : acc_x + p_x;
			acc_y <= p_first ? p_y : acc_y + p_y;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			p_en <= 1'b0;
			p_first <= 1'b0;
			a_en <= 1'b0;
		end
		else
		begin
			p_en <= mac_en;
			p_first <= mac_first;
			a_en <= p_en;
		end
	end

	// sum is complete once no continuation product follows it
	assign acc_valid = a_en && (!p_en || p_first);

endmodule

/* rtl/output_stage.sv */
module output_stage (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            mrst,
	input  pfir_pkg::acc_t  acc_x,
	input  pfir_pkg::acc_t  acc_y,
	input  logic            out_load,
	input  logic            oe,
	output logic            out_full,
	output pfir_pkg::dout_t dox,
	output pfir_pkg::dout_t doy,
	output logic            ov,
	output logic            ovf
);
	import pfir_pkg::*;

	// returns {overflow, value}
	function automatic logic [DOUT_W:0] round_sat(input acc_t a);
		acc_t r;
		logic signed [ACC_W-OUT_SHIFT-1:0] q;
		logic [ACC_W-OUT_SHIFT-DOUT_W:0] top;
		r = a + (acc_t'(1) << (OUT_SHIFT - 1));
		q = r[ACC_W-1:OUT_SHIFT];
		top = q[ACC_W-OUT_SHIFT-1:DOUT_W-1];
		if (&top || ~|top)
			return {1'b0, q[DOUT_W-1:0]};
		else if (q[ACC_W-OUT_SHIFT-1])
			return {2'b11, {(DOUT_W-1){1'b0}}};
		else
			return {2'b10, {(DOUT_W-1){1'b1}}};
	endfunction

	logic [DOUT_W:0] sat_x;
	logic [DOUT_W:0] sat_y;

	// rounded result waiting for the output register
	dout_t rnd_x;
	dout_t rnd_y;
	logic  rnd_ovf;
	logic  rnd_full;

	// output register holds a result not yet shown
	logic pend;
	logic move;

	assign sat_x = round_sat(acc_x);
	assign sat_y = round_sat(acc_y);

	assign move = rnd_full && (!pend || oe);
	assign ov = pend && oe;
	assign out_full = rnd_full || pend;

	always_ff @(posedge clk)
	begin
		if (out_load)
		begin
			rnd_x <= sat_x[DOUT_W-1:0];
			rnd_y <= sat_y[DOUT_W-1:0];
			rnd_ovf <= sat_x[DOUT_W] || sat_y[DOUT_W];
		end
		if (move)
		begin
			dox <= rnd_x;
			doy <= rnd_y;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rnd_full <= 1'b0;
			pend <= 1'b0;
			ovf <= 1'b0;
		end
		else if (mrst)
		begin
			rnd_full <= 1'b0;
			pend <= 1'b0;
			ovf <= 1'b0;
		end
		else
		begin
			if (out_load)
				rnd_full <= 1'b1;
			else if (move)
				rnd_full <= 1'b0;
			// shown for one enabled cycle, then freed
			if (move)
			begin
				pend <= 1'b1;
				ovf <= rnd_ovf;
			end
			else if (ov)
				pend <= 1'b0;
		end
	end

endmodule

/* rtl/pfir_top.sv */
module pfir_top (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              mrst,
	input  pfir_pkg::sample_t dix,
	input  pfir_pkg::sample_t diy,
	input  logic              iv,
	output logic              rfd,
	output pfir_pkg::dout_t   dox,
	output pfir_pkg::dout_t   doy,
	output logic              ov,
	output logic              ovf,
	input  logic              oe,
	input  pfir_pkg::dec_t    dec,
	input  pfir_pkg::tap_t    ncoef,
	input  pfir_pkg::prog_t   pdata,
	input  logic              pwr,
	input  logic              prst
);
	import pfir_pkg::*;

	logic    samp_we;
	tap_t    rd_tap;
	coef_t   rd_coef;
	sample_t rd_x;
	sample_t rd_y;
	logic    mac_first;
	logic    mac_en;
	acc_t    acc_x;
	acc_t    acc_y;
	logic    acc_valid;
	logic    out_load;
	logic    out_full;

	fir_control u_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.mrst(mrst),
		.iv(iv),
		.rfd(rfd),
		.dec(dec),
		.ncoef(ncoef),
		.samp_we(samp_we),
		.rd_tap(rd_tap),
		.mac_first(mac_first),
		.mac_en(mac_en),
		.acc_valid(acc_valid),
		.out_full(out_full),
		.out_load(out_load)
	);

	coef_store u_coef (
		.clk(clk),
		.rst_n(rst_n),
		.pdata(pdata),
		.pwr(pwr),
		.prst(prst),
		.rd_tap(rd_tap),
		.rd_coef(rd_coef)
	);

	sample_buffer u_samp (
		.clk(clk),
		.rst_n(rst_n),
		.mrst(mrst),
		.dix(dix),
		.diy(diy),
		.samp_we(samp_we),
		.rd_tap(rd_tap),
		.rd_x(rd_x),
		.rd_y(rd_y)
	);

	mac_unit u_mac (
		.clk(clk),
		.rst_n(rst_n),
		.rd_x(rd_x),
		.rd_y(rd_y),
		.rd_coef(rd_coef),
		.mac_first(mac_first),
		.mac_en(mac_en),
		.acc_x(acc_x),
		.acc_y(acc_y),
		.acc_valid(acc_valid)
	);

	output_stage u_out (
		.clk(clk),
		.rst_n(rst_n),
		.mrst(mrst),
		.acc_x(acc_x),
		.acc_y(acc_y),
		.out_load(out_load),
		.oe(oe),
		.out_full(out_full),
		.dox(dox),
		.doy(doy),
		.ov(ov),
		.ovf(ovf)
	);

endmodule

/* bench/fir_model.svh */
`ifndef FIR_MODEL_SVH
`define FIR_MODEL_SVH

// index 0 holds the newest sample
typedef sample_t hist_t [NTAPS];
typedef coef_t taps_t [NTAPS];

// round half up at the output LSB, then clip to the output range
function automatic longint scale_output(input longint acc, output logic clipped);
	longint q;
	longint lim;
	lim = longint'(1) <<< (DOUT_W - 1);
	q = (acc + (longint'(1) <<< (OUT_SHIFT - 1))) >>> OUT_SHIFT;
	clipped = 1'b0;
	if (q > lim - 1)
	begin
		q = lim - 1;
		clipped = 1'b1;
	end
	else if (q < -lim)
	begin
		q = -lim;
		clipped = 1'b1;
	end
	return q;
endfunction

// returns {ovf, dox, doy} for taps 0 to last
function automatic logic [2*DOUT_W:0] fir_expected(input hist_t hx, input hist_t hy,
	input taps_t cf, input int last);
	longint sx;
	longint sy;
	longint qx;
	longint qy;
	logic cx;
	logic cy;
	sx = 0;
	sy = 0;
	for (int k = 0; k <= last; k++)
	begin
		sx += longint'(hx[k]) * longint'(cf[k]);
		sy += longint'(hy[k]) * longint'(cf[k]);
	end
	qx = scale_output(sx, cx);
	qy = scale_output(sy, cy);
	return {cx || cy, qx[DOUT_W-1:0], qy[DOUT_W-1:0]};
endfunction

`endif

/* bench/tb_pfir.sv */
module tb_pfir;
	timeunit 1ns;
	timeprecision 100ps;

	import pfir_pkg::*;
	`include "fir_model.svh"

	// samples per test
	localparam int N_IMP = 32;
	localparam int N_RND = 200;
	localparam int N_DEC = 60;
	localparam int N_SAT = 40;
	localparam int N_BP = 120;
	localparam int N_CLR = 17;
	localparam int CYCLE_LIMIT = N_IMP * (15 + 8) + N_RND * (31 + 8) + N_DEC * (20 + 8)
		+ N_SAT * (15 + 8) + N_BP * (7 + 8) + N_CLR * (10 + 8) + 6000;

	logic clk;
	logic rst_n;
	logic mrst;
	sample_t dix;
	sample_t diy;
	logic iv;
	logic rfd;
	dout_t dox;
	dout_t doy;
	logic ov;
	logic ovf;
	logic oe;
	dec_t dec;
	tap_t ncoef;
	prog_t pdata;
	logic pwr;
	logic prst;

	integer seed;
	int errors;
	int checks;
	int cycles;
	int dcount;
	int oe_left;
	logic bp_on;
	hist_t hist_x;
	hist_t hist_y;
	taps_t coefs;
	sample_t stim_x [256];
	sample_t stim_y [256];
	logic [2*DOUT_W:0] exp_q [$];
	logic [2*DOUT_W:0] exp_word;

	pfir_top UUT (
		.clk(clk), .rst_n(rst_n), .mrst(mrst), .dix(dix), .diy(diy), .iv(iv), .rfd(rfd),
		.dox(dox), .doy(doy), .ov(ov), .ovf(ovf), .oe(oe), .dec(dec), .ncoef(ncoef),
		.pdata(pdata), .pwr(pwr), .prst(prst)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic check_value(input longint got, input longint exp, input string what);
		checks++;
		if (got != exp)
		begin
			$display("ERR %0t: %s, got %0d, expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	// prst first then low and high word per coefficient while mrst holds the filter
	task automatic load_coefs(input int count);
		mrst = 1'b1;
		prst = 1'b1;
		@(negedge clk);
		prst = 1'b0;
		for (int k = 0; k < count; k++)
		begin
			pwr = 1'b1;
			pdata = coefs[k][15:0];
			@(negedge clk);
			pdata = {4'ha, coefs[k][COEF_W-1:16]};
			@(negedge clk);
		end
		pwr = 1'b0;
		mrst = 1'b0;
	endtask

	task automatic random_coefs(input int count);
		for (int k = 0; k < count; k++)
		begin
			coefs[k] = $random(seed);
			// keep most sums inside the output range
			coefs[k] = coefs[k] >>> 5;
		end
	endtask

	task automatic random_samples(input int count);
		for (int k = 0; k < count; k++)
		begin
			stim_x[k] = $random(seed);
			stim_y[k] = $random(seed);
		end
	endtask

	// iv stays up until the DUT takes the sample
	task automatic send_sample(input sample_t x, input sample_t y);
		iv = 1'b1;
		dix = x;
		diy = y;
		#3;
		while (!rfd)
		begin
			@(negedge clk);
			#3;
		end
		@(negedge clk);
	endtask

	task automatic send_block(input int count);
		for (int k = 0; k < count; k++)
			send_sample(stim_x[k], stim_y[k]);
	endtask

	task automatic wait_drain();
		int waited;
		iv = 1'b0;
		waited = 0;
		// the last result needs at most ncoef+6 cycles once input stops
		while (exp_q.size() != 0 && waited < NTAPS + 16)
		begin
			@(negedge clk);
			waited++;
		end
		repeat (6) @(negedge clk);
	endtask

	// monitor samples just before the rising edge
	always @(negedge clk)
	begin
		#3;
		if (rst_n && mrst)
		begin
			for (int k = 0; k < NTAPS; k++)
			begin
				hist_x[k] = '0;
				hist_y[k] = '0;
			end
			dcount = 0;
		end
		else if (rst_n)
		begin
			if (exp_q.size() != 0)
				check_value(rfd, 0, "rfd high while a result is pending");
			if (iv && rfd)
			begin
				for (int k = NTAPS - 1; k > 0; k--)
				begin
					hist_x[k] = hist_x[k-1];
					hist_y[k] = hist_y[k-1];
				end
				hist_x[0] = dix;
				hist_y[0] = diy;
				dcount++;
				// dec of 0 counts like 1
				if (dcount >= ((dec == 0) ? 1 : int'(dec)))
				begin
					dcount = 0;
					exp_q.push_back(fir_expected(hist_x, hist_y, coefs, int'(ncoef)));
				end
			end
		end
	end

	always @(negedge clk)
	begin
		#3;
		if (rst_n && ov)
		begin
			if (exp_q.size() == 0)
			begin
				$display("unexpected output at %0t with no result outstanding", $time);
				errors++;
			end
			else
			begin
				exp_word = exp_q.pop_front();
				check_value(dox, dout_t'(exp_word[2*DOUT_W-1:DOUT_W]), "dox");
				check_value(doy, dout_t'(exp_word[DOUT_W-1:0]), "doy");
				check_value(ovf, exp_word[2*DOUT_W], "ovf");
			end
		end
	end

	// random oe runs during the back-pressure test
	always @(negedge clk)
	begin
		if (!bp_on)
			oe = 1'b1;
		else if (oe_left == 0)
		begin
			oe = $random(seed);
			oe_left = $random(seed) & 7;
		end
		else
			oe_left--;
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > CYCLE_LIMIT)
		begin
			$display("timeout after %0d cycles, the DUT stopped producing results", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	initial
	begin
		seed = 16338;
		errors = 0;
		checks = 0;
		cycles = 0;
		dcount = 0;
		oe_left = 0;
		bp_on = 1'b0;
		rst_n = 1'b0;
		mrst = 1'b0;
		iv = 1'b0;
		dix = '0;
		diy = '0;
		oe = 1'b1;
		dec = 1;
		ncoef = '0;
		pdata = '0;
		pwr = 1'b0;
		prst = 1'b0;
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		#3;
		check_value(rfd, 1, "rfd after reset");
		check_value(ov, 0, "ov after reset");
		check_value(ovf, 0, "ovf after reset");
		@(negedge clk);

		// impulse with alternating signs so every tap is distinct
		dec = 1;
		ncoef = 15;
		for (int k = 0; k < 16; k++)
			coefs[k] = (k % 2) ? -((k + 1) * (1 << 22)) : (k + 1) * (1 << 22);
		load_coefs(16);
		for (int k = 0; k < N_IMP; k++)
		begin
			stim_x[k] = (k == 0) ? 18'sh1ffff : '0;
			stim_y[k] = (k == 0) ? 18'sh20000 : '0;
		end
		send_block(N_IMP);
		wait_drain();

		// random data over the full length
		ncoef = 31;
		random_coefs(32);
		load_coefs(32);
		random_samples(N_RND);
		send_block(N_RND);
		wait_drain();

		// decimation by 5
		dec = 5;
		ncoef = 20;
		random_coefs(21);
		load_coefs(21);
		random_samples(N_DEC);
		send_block(N_DEC);
		wait_drain();

		// full scale into large positive taps followed by a small input
		dec = 1;
		ncoef = 15;
		for (int k = 0; k < 16; k++)
			coefs[k] = 1 << 26;
		load_coefs(16);
		for (int k = 0; k < N_SAT; k++)
		begin
			stim_x[k] = (k < N_SAT / 2) ? 18'sh1ffff : 18'sd100;
			stim_y[k] = (k < N_SAT / 2) ? 18'sh20000 : -18'sd77;
		end
		send_block(N_SAT);
		wait_drain();

		// back-pressure with data drawn before oe starts using the seed
		ncoef = 7;
		random_coefs(8);
		load_coefs(8);
		random_samples(N_BP);
		@(posedge clk);
		bp_on = 1'b1;
		@(negedge clk);
		send_block(N_BP);
		iv = 1'b0;
		@(posedge clk);
		bp_on = 1'b0;
		@(negedge clk);
		wait_drain();

		// clear mid-stream with the decimation count part way
		dec = 3;
		ncoef = 10;
		random_coefs(11);
		load_coefs(11);
		random_samples(8);
		send_block(8);
		wait_drain();
		mrst = 1'b1;
		repeat (2) @(negedge clk);
		mrst = 1'b0;
		random_samples(N_CLR - 8);
		send_block(N_CLR - 8);
		wait_drain();

		repeat (20) @(negedge clk);
		if (exp_q.size() != 0)
		begin
			$display("%0d expected results never appeared on the output", exp_q.size());
			errors += exp_q.size();
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* build.f */
+incdir+bench
rtl/pfir_pkg.sv
rtl/coef_store.sv
rtl/sample_buffer.sv
rtl/fir_control.sv
rtl/mac_unit.sv
rtl/output_stage.sv
rtl/pfir_top.sv
bench/tb_pfir.sv
